/* include/rdp_consts.svh */
// Constants of the upstream receive path: widths, framing codes, option ids
// and receive FIFO sizing. Include wherever one of them is needed.

`ifndef RDP_CONSTS_SVH
`define RDP_CONSTS_SVH

// Framing code (bit 0 marks a start, bit 1 marks an end)
`define RDP_CNTL_WIDTH         2
`define RDP_CNTL_MOM           2'b00
`define RDP_CNTL_SOM           2'b01
`define RDP_CNTL_EOM           2'b10
`define RDP_CNTL_SOM_EOM       2'b11

// Upstream word, two {id, value} tuples of 16 bits each
`define RDP_DATA_WIDTH         32
`define RDP_OPT_ID_WIDTH       4
`define RDP_OPT_VALUE_WIDTH    12

// Option ids
`define RDP_OPT_NOP            4'd0
`define RDP_OPT_STOP_CMD       4'd1
`define RDP_OPT_TAG            4'd2
`define RDP_OPT_NUM_LANES      4'd3

`define RDP_TAG_WIDTH          8
`define RDP_NUM_LANES          32    // Lane count field gives highest active lane

// Receive FIFO
`define RDP_RX_FIFO_DEPTH      16
`define RDP_RX_FIFO_THRESHOLD  12    // Leaves room for words still in flight

`endif

/* verilog/rdp_pkg.sv */
// Types shared by the upstream receive path modules.
// Referenced by scoped name, e.g. rdp_pkg::rdp_word_t.

`default_nettype none

`include "rdp_consts.svh"

package rdp_pkg;

  typedef logic [`RDP_CNTL_WIDTH-1:0]      cntl_t;
  typedef logic [`RDP_DATA_WIDTH-1:0]      data_t;
  typedef logic [`RDP_OPT_VALUE_WIDTH-1:0] opt_value_t;
  typedef logic [`RDP_TAG_WIDTH-1:0]       tag_t;
  typedef logic [`RDP_NUM_LANES-1:0]       lane_mask_t;

  // One upstream bus word as held in the receive FIFO
  typedef struct packed {
    cntl_t cntl;
    data_t data;
  } rdp_word_t;

  // Options latched from the current OOB packet
  typedef struct packed {
    logic       contained_stop;   // Packet carried a stop command
    opt_value_t stop_ptr;
    tag_t       tag;
    lane_mask_t lanes_active;
  } oob_cfg_t;

  typedef enum logic [2:0] {
    WAIT, SOM, MOM, START, OP_RUNNING, WAIT_COMPLETE_DEASSERTED, COMPLETE, ERR
  } rx_state_t;

endpackage

`default_nettype wire

/* verilog/rdp_rx_fifo.sv */
// Receive FIFO for upstream words, with almost-full status for flow control
// and a fifo stage plus a pipe stage prefetching toward the packet logic.

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_rx_fifo
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               write,
  input  rdp_pkg::rdp_word_t write_word,
  output logic               almost_full,
  output logic               head_valid,
  output rdp_pkg::rdp_word_t head_word,
  input  logic               head_read
);

  localparam int unsigned DEPTH = `RDP_RX_FIFO_DEPTH;
  localparam int unsigned AW    = $clog2(DEPTH);
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  rdp_pkg::rdp_word_t mem [DEPTH];
  logic [AW-1:0]      wr_ptr;
  logic [AW-1:0]      rd_ptr;
  logic [CW-1:0]      count;        // Entries held in mem
  logic               wr_en;
  logic               mem_read;
  logic               fifo_valid;
  logic               fifo_read;
  logic               pipe_valid;
  rdp_pkg::rdp_word_t fifo_word;
  rdp_pkg::rdp_word_t pipe_word;

  assign wr_en       = write && (count != CW'(DEPTH));
  assign mem_read    = (count != '0) && (!fifo_valid || fifo_read);  // Keep fifo stage charged
  assign fifo_read   = fifo_valid && (!pipe_valid || head_read);     // Keep pipe stage charged
  assign almost_full = count >= CW'(`RDP_RX_FIFO_THRESHOLD);

  // --------------------
  // Storage and payload stages

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= write_word;
    if (mem_read)
      fifo_word <= mem[rd_ptr];
    if (fifo_read)
      pipe_word <= fifo_word;
  end

  // --------------------
  // Pointers, occupancy and stage valids

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      fifo_valid <= 1'b0;
      pipe_valid <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (mem_read)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

      case ({wr_en, mem_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      if (mem_read)
        fifo_valid <= 1'b1;
      else if (fifo_read)
        fifo_valid <= 1'b0;

      if (fifo_read)
        pipe_valid <= 1'b1;
      else if (head_read)
        pipe_valid <= 1'b0;     // Head consumed, nothing behind it
    end
  end

  assign head_valid = pipe_valid;
  assign head_word  = pipe_word;

endmodule

`default_nettype wire

/* verilog/rdp_oob_parser.sv */
// Option decoder for OOB packets. Scans both {id, value} tuples of every
// accepted word and latches stop pointer, tag and active lane mask.

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_oob_parser
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               word_accept,
  input  logic               pkt_first,
  input  logic               op_done,
  input  rdp_pkg::rdp_word_t head_word,
  output rdp_pkg::oob_cfg_t  cfg
);

  localparam int unsigned ID_W    = `RDP_OPT_ID_WIDTH;
  localparam int unsigned VALUE_W = `RDP_OPT_VALUE_WIDTH;
  localparam int unsigned TUPLE_W = ID_W + VALUE_W;
  localparam int unsigned LANE_W  = $clog2(`RDP_NUM_LANES);

  localparam logic [LANE_W-1:0]   LANE_MAX  = LANE_W'(`RDP_NUM_LANES - 1);
  localparam rdp_pkg::lane_mask_t ALL_LANES = '1;

  // Returns {hit, value} for the given id, tuple 0 wins over tuple 1
  function automatic logic [VALUE_W:0] find_opt(input rdp_pkg::data_t data,
                                                input logic [ID_W-1:0] opt_id);
    logic [TUPLE_W-1:0] t0;
    logic [TUPLE_W-1:0] t1;
    t0 = data[TUPLE_W-1:0];
    t1 = data[2*TUPLE_W-1:TUPLE_W];
    if (t0[TUPLE_W-1 -: ID_W] == opt_id)
      return {1'b1, t0[VALUE_W-1:0]};
    else if (t1[TUPLE_W-1 -: ID_W] == opt_id)
      return {1'b1, t1[VALUE_W-1:0]};
    else
      return '0;
  endfunction

  logic [VALUE_W:0]    stop_hit;
  logic [VALUE_W:0]    tag_hit;
  logic [VALUE_W:0]    lanes_hit;
  logic [LANE_W-1:0]   lane_cnt;
  rdp_pkg::lane_mask_t lane_mask;

  assign stop_hit  = find_opt(head_word.data, `RDP_OPT_STOP_CMD);
  assign tag_hit   = find_opt(head_word.data, `RDP_OPT_TAG);
  assign lanes_hit = find_opt(head_word.data, `RDP_OPT_NUM_LANES);

  assign lane_cnt  = lanes_hit[LANE_W-1:0];             // Highest active lane
  assign lane_mask = ALL_LANES >> (LANE_MAX - lane_cnt); // Lanes 0 to lane_cnt

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cfg.contained_stop <= 1'b0;
      cfg.stop_ptr       <= '0;
      cfg.tag            <= '0;
      cfg.lanes_active   <= ALL_LANES;
    end
    else
    begin
      if (word_accept && stop_hit[VALUE_W])
      begin
        cfg.contained_stop <= 1'b1;
        cfg.stop_ptr       <= stop_hit[VALUE_W-1:0];
      end
      else if (op_done)
        cfg.contained_stop <= 1'b0;   // Packet fully handled

      if (word_accept && tag_hit[VALUE_W])
        cfg.tag <= tag_hit[`RDP_TAG_WIDTH-1:0];

      // No lane count in the packet means all lanes
      if (word_accept && lanes_hit[VALUE_W])
        cfg.lanes_active <= lane_mask;
      else if (pkt_first)
        cfg.lanes_active <= ALL_LANES;
    end
  end

endmodule

`default_nettype wire

/* verilog/rdp_rx_fsm.sv */
// Framing check of the OOB packets and sequencing of one streaming operation
// per packet: start pulse, completion handshake, then tag hand-off.

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_rx_fsm
(
  input  logic           clk,
  input  logic           rst_n,
  input  logic           head_valid,
  input  rdp_pkg::cntl_t head_cntl,
  input  logic           contained_stop,
  input  logic           op_complete,
  input  logic           tag_ready,
  output logic           head_read,
  output logic           word_accept,
  output logic           pkt_first,
  output logic           op_done,
  output logic           op_start,
  output logic           tag_valid,
  output logic           framing_error
);

  rdp_pkg::rx_state_t state;
  rdp_pkg::rx_state_t state_next;
  logic               tag_ready_q;     // SIMD ready, one cycle late

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= rdp_pkg::WAIT;
      tag_ready_q <= 1'b0;
    end
    else
    begin
      state       <= state_next;
      tag_ready_q <= tag_ready;
    end
  end

  // --------------------
  // Next state

  always_comb
  begin
    state_next = state;
    case (state)
      rdp_pkg::WAIT:
        if (head_valid)
          case (head_cntl)
            `RDP_CNTL_SOM:     state_next = rdp_pkg::SOM;
            `RDP_CNTL_SOM_EOM: state_next = rdp_pkg::START;
            default:           state_next = rdp_pkg::ERR;   // Packet must open first
          endcase
      rdp_pkg::SOM, rdp_pkg::MOM:
        if (head_valid)
          case (head_cntl)
            `RDP_CNTL_MOM: state_next = rdp_pkg::MOM;
            `RDP_CNTL_EOM: state_next = rdp_pkg::START;
            default:       state_next = rdp_pkg::ERR;
          endcase
      // One cycle only, op_start is a pulse
      rdp_pkg::START:
        state_next = contained_stop ? rdp_pkg::OP_RUNNING : rdp_pkg::COMPLETE;
      rdp_pkg::OP_RUNNING:
        if (op_complete)
          state_next = rdp_pkg::WAIT_COMPLETE_DEASSERTED;
      rdp_pkg::WAIT_COMPLETE_DEASSERTED:
        if (!op_complete)
          state_next = rdp_pkg::COMPLETE;
      rdp_pkg::COMPLETE:
        if (tag_ready_q)
          state_next = rdp_pkg::WAIT;
      default:
        state_next = rdp_pkg::ERR;      // Locked until reset
    endcase
  end

  // --------------------
  // Outputs

  assign head_read     = head_valid && (state == rdp_pkg::WAIT || state == rdp_pkg::SOM ||
                                        state == rdp_pkg::MOM);
  assign word_accept   = head_read;
  assign pkt_first     = head_read && (state == rdp_pkg::WAIT);
  assign op_done       = (state == rdp_pkg::COMPLETE) && tag_ready_q;
  assign tag_valid     = op_done;      // Tag goes out as the packet retires
  assign op_start      = (state == rdp_pkg::START) && contained_stop;
  assign framing_error = (state == rdp_pkg::ERR);

endmodule

`default_nettype wire

/* verilog/rdp_cntl.sv */
// Upstream receive path of the data-path controller. Registers the stack bus,
// buffers words, checks OOB framing and drives one operation per packet.

`timescale 1ns/1ps
`default_nettype none

module rdp_cntl
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  rdp_pkg::rdp_word_t  in_word,
  output logic                in_ready,
  input  logic                op_complete,
  input  logic                tag_ready,
  output logic                op_start,
  output rdp_pkg::opt_value_t op_ptr,
  output logic                tag_valid,
  output rdp_pkg::tag_t       tag,
  output rdp_pkg::lane_mask_t lanes_active,
  output logic                framing_error
);

  logic               in_valid_q;
  rdp_pkg::rdp_word_t in_word_q;
  logic               almost_full;
  logic               head_valid;
  rdp_pkg::rdp_word_t head_word;
  logic               head_read;
  logic               word_accept;
  logic               pkt_first;
  logic               op_done;
  rdp_pkg::oob_cfg_t  cfg;

  // --------------------
  // Registered bus inputs and ready

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_valid_q <= 1'b0;
      in_ready   <= 1'b0;
    end
    else
    begin
      in_valid_q <= in_valid;
      in_ready   <= !almost_full;
    end
  end

  always_ff @(posedge clk)
    in_word_q <= in_word;

  rdp_rx_fifo rx_fifo_i
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .write       (in_valid_q),
    .write_word  (in_word_q),
    .almost_full (almost_full),
    .head_valid  (head_valid),
    .head_word   (head_word),
    .head_read   (head_read)
  );

  rdp_oob_parser oob_parser_i
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .word_accept (word_accept),
    .pkt_first   (pkt_first),
    .op_done     (op_done),
    .head_word   (head_word),
    .cfg         (cfg)
  );

  rdp_rx_fsm rx_fsm_i
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .head_valid     (head_valid),
    .head_cntl      (head_word.cntl),
    .contained_stop (cfg.contained_stop),
    .op_complete    (op_complete),
    .tag_ready      (tag_ready),
    .head_read      (head_read),
    .word_accept    (word_accept),
    .pkt_first      (pkt_first),
    .op_done        (op_done),
    .op_start       (op_start),
    .tag_valid      (tag_valid),
    .framing_error  (framing_error)
  );

  assign op_ptr       = cfg.stop_ptr;
  assign tag          = cfg.tag;
  assign lanes_active = cfg.lanes_active;

endmodule

`default_nettype wire

/* sim/rdp_cntl_tb.sv */
// Directed testbench for the upstream receive path. Sends OOB packets on the
// stack bus, models the operation unit and the SIMD unit, checks the outputs.

`timescale 1ns/1ps
`default_nettype none

`include "rdp_consts.svh"

module rdp_cntl_tb;

  localparam int unsigned TIMEOUT_CYCLES = 4000;  // Tests need about 500 cycles

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  rdp_pkg::rdp_word_t  in_word;
  logic                in_ready;
  logic                op_complete;
  logic                tag_ready;
  logic                op_start;
  rdp_pkg::opt_value_t op_ptr;
  logic                tag_valid;
  rdp_pkg::tag_t       tag;
  rdp_pkg::lane_mask_t lanes_active;
  logic                framing_error;

  int unsigned         errors;
  int unsigned         checks;
  int unsigned         cycle_cnt;
  integer              seed;
  logic                op_hold;      // Operation unit holds off completion
  rdp_pkg::opt_value_t start_q[$];   // op_ptr at each op_start
  rdp_pkg::tag_t       tag_q[$];     // tag at each tag_valid
  rdp_pkg::opt_value_t no_starts[$];

  rdp_cntl rdp_cntl_i
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid      (in_valid),
    .in_word       (in_word),
    .in_ready      (in_ready),
    .op_complete   (op_complete),
    .tag_ready     (tag_ready),
    .op_start      (op_start),
    .op_ptr        (op_ptr),
    .tag_valid     (tag_valid),
    .tag           (tag),
    .lanes_active  (lanes_active),
    .framing_error (framing_error)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Monitors and unit models

  always @(negedge clk)
  begin
    if (op_start)
      start_q.push_back(op_ptr);
    if (tag_valid)
      tag_q.push_back(tag);
  end

  // Raises op_complete a few cycles after each start, then drops it
  initial
  begin
    op_complete = 1'b0;
    forever
    begin
      @(negedge clk);
      if (op_start)
      begin
        while (op_hold)
          @(negedge clk);
        repeat (3) @(negedge clk);
        op_complete = 1'b1;
        repeat (2) @(negedge clk);
        op_complete = 1'b0;
      end
    end
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

  // --------------------
  // Helpers

  task automatic expect_true(input bit ok, input string what);
    checks++;
    assert (ok)
    else
    begin
      errors++;
      $display("Fail at %0d ns: %s", $time, what);
    end
  endtask

  // Tuple 1 in the high half, tuple 0 in the low half
  function automatic rdp_pkg::rdp_word_t pack_word(input rdp_pkg::cntl_t cntl,
      input logic [3:0] id1, input rdp_pkg::opt_value_t val1,
      input logic [3:0] id0, input rdp_pkg::opt_value_t val0);
    rdp_pkg::rdp_word_t w;
    w.cntl = cntl;
    w.data = {id1, val1, id0, val0};
    return w;
  endfunction

  function automatic rdp_pkg::lane_mask_t lanes_upto(input int unsigned n);
    rdp_pkg::lane_mask_t m;
    for (int i = 0; i < `RDP_NUM_LANES; i++)
      m[i] = (i <= n);
    return m;
  endfunction

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic send_word(input rdp_pkg::rdp_word_t w);
    while (!in_ready)
      @(negedge clk);
    in_valid = 1'b1;
    in_word  = w;
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk);
  endtask

  task automatic wait_tags(input int unsigned n);
    while (tag_q.size() < n)
      @(negedge clk);
  endtask

  task automatic clear_queues();
    start_q.delete();
    tag_q.delete();
  endtask

  task automatic check_starts(input rdp_pkg::opt_value_t exp[$], input string name);
    expect_true(start_q.size() == exp.size(), $sformatf("%s: %0d op_start pulses, expected %0d",
                name, start_q.size(), exp.size()));
    for (int i = 0; i < exp.size() && i < start_q.size(); i++)
      expect_true(start_q[i] == exp[i], $sformatf("%s: op_ptr %0d is %h, expected %h",
                  name, i, start_q[i], exp[i]));
  endtask

  task automatic check_tag(input rdp_pkg::tag_t exp, input string name);
    expect_true(tag_q.size() == 1, $sformatf("%s: %0d tag_valid pulses, expected 1",
                name, tag_q.size()));
    if (tag_q.size() > 0)
      expect_true(tag_q[0] == exp, $sformatf("%s: tag %h, expected %h", name, tag_q[0], exp));
  endtask

  // --------------------
  // Directed tests

  task automatic test_single_word();
    rdp_pkg::opt_value_t exp_q[$];
    rdp_pkg::opt_value_t stop_val;
    rdp_pkg::tag_t       tag_val;
    stop_val = rdp_pkg::opt_value_t'($random(seed));
    tag_val  = rdp_pkg::tag_t'($random(seed));
    exp_q.push_back(stop_val);
    clear_queues();
    send_word(pack_word(`RDP_CNTL_SOM_EOM, `RDP_OPT_TAG, {4'h0, tag_val},
                        `RDP_OPT_STOP_CMD, stop_val));
    wait_tags(1);
    wait_cycles(5);
    check_starts(exp_q, "single word");
    check_tag(tag_val, "single word");
    expect_true(lanes_active == '1, $sformatf("single word: lanes %h", lanes_active));
  endtask

  task automatic test_lane_count();
    int unsigned n;
    n = $unsigned($random(seed)) % 31;
    clear_queues();
    send_word(pack_word(`RDP_CNTL_SOM, `RDP_OPT_NOP, 12'h000, `RDP_OPT_TAG, 12'h0a5));
    send_word(pack_word(`RDP_CNTL_MOM, `RDP_OPT_NUM_LANES, 12'(n), `RDP_OPT_NOP, 12'h000));
    send_word(pack_word(`RDP_CNTL_EOM, `RDP_OPT_NOP, 12'h000, `RDP_OPT_NOP, 12'h000));
    wait_tags(1);
    expect_true(lanes_active == lanes_upto(n), $sformatf("lane count %0d: lanes %h",
                n, lanes_active));
    check_tag(8'ha5, "lane count");
    check_starts(no_starts, "lane count");
    clear_queues();
    send_word(pack_word(`RDP_CNTL_SOM_EOM, `RDP_OPT_NOP, 12'h000, `RDP_OPT_TAG, 12'h03c));
    wait_tags(1);
    expect_true(lanes_active == '1, $sformatf("lanes not restored: %h", lanes_active));
  endtask

  task automatic test_tag_ready();
    tag_ready = 1'b0;           // SIMD unit busy
    clear_queues();
    send_word(pack_word(`RDP_CNTL_SOM_EOM, `RDP_OPT_NOP, 12'h000, `RDP_OPT_TAG, 12'h05e));
    wait_cycles(20);
    expect_true(tag_q.size() == 0, "tag_valid fired while tag_ready was low");
    tag_ready = 1'b1;
    wait_tags(1);
    wait_cycles(5);
    check_tag(8'h5e, "tag ready");
    check_starts(no_starts, "tag ready");
  endtask

  task automatic test_backpressure();
    rdp_pkg::opt_value_t exp_q[$];
    rdp_pkg::opt_value_t stop_val;
    bit                  ready_dropped;
    ready_dropped = 1'b0;
    clear_queues();
    op_hold = 1'b1;
    fork
      begin
        for (int i = 0; i < 20; i++)
        begin
          stop_val = rdp_pkg::opt_value_t'($random(seed));
          exp_q.push_back(stop_val);
          send_word(pack_word(`RDP_CNTL_SOM_EOM, `RDP_OPT_TAG, 12'(i),
                              `RDP_OPT_STOP_CMD, stop_val));
        end
      end
      begin
        for (int n = 0; n < 100 && in_ready; n++)
          @(negedge clk);
        ready_dropped = !in_ready;
        wait_cycles(4);
        op_hold = 1'b0;         // Let the queued operations drain
      end
    join
    wait_tags(20);
    wait_cycles(5);
    expect_true(ready_dropped, "in_ready never dropped under back-pressure");
    check_starts(exp_q, "back-pressure");
  endtask

  task automatic test_framing_error();
    rdp_pkg::opt_value_t exp_q[$];
    rdp_pkg::opt_value_t stop_val;
    clear_queues();
    send_word(pack_word(`RDP_CNTL_MOM, `RDP_OPT_NOP, 12'h000, `RDP_OPT_NOP, 12'h000));
    while (!framing_error)
      @(negedge clk);
    send_word(pack_word(`RDP_CNTL_SOM_EOM, `RDP_OPT_TAG, 12'h011, `RDP_OPT_STOP_CMD, 12'h123));
    wait_cycles(30);
    expect_true(framing_error, "framing_error dropped before reset");
    check_starts(no_starts, "locked");
    apply_reset();
    clear_queues();
    expect_true(!framing_error, "framing_error still high after reset");
    stop_val = rdp_pkg::opt_value_t'($random(seed));
    exp_q.push_back(stop_val);
    send_word(pack_word(`RDP_CNTL_SOM_EOM, `RDP_OPT_TAG, 12'h022, `RDP_OPT_STOP_CMD, stop_val));
    wait_tags(1);
    wait_cycles(5);
    check_starts(exp_q, "after reset");
  endtask

  initial
  begin
    seed      = 32'h2721_186a;
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_word   = '0;
    tag_ready = 1'b1;
    op_hold   = 1'b0;
    apply_reset();
    test_single_word();
    test_lane_count();
    test_tag_ready();
    test_backpressure();
    test_framing_error();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
verilog/rdp_pkg.sv
verilog/rdp_rx_fifo.sv
verilog/rdp_oob_parser.sv
verilog/rdp_rx_fsm.sv
verilog/rdp_cntl.sv
sim/rdp_cntl_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the rdp_cntl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module rdp_cntl_tb -f all.f -o rdp_cntl_tb_sim

out=$(./obj_dir/rdp_cntl_tb_sim)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi
